// File: verilog/lc4_defines.svh
`ifndef LC4_DEFINES_SVH
`define LC4_DEFINES_SVH

// datapath and address width
`define LC4_WORD_W   16

// architectural register file
`define LC4_NUM_REGS 8
`define LC4_RSEL_W   3

// first fetch address out of reset
`define LC4_RESET_PC 16'h8200

`endif

// File: verilog/lc4_isa_pkg.sv
`include "lc4_defines.svh"

package lc4_isa_pkg;

    typedef logic [`LC4_WORD_W-1:0] word_t;
    typedef logic [`LC4_RSEL_W-1:0] rsel_t;

    // values match insn[15:12]
    typedef enum logic [3:0] {
        OP_BR    = 4'h0,
        OP_ARITH = 4'h1,
        OP_LOGIC = 4'h5,
        OP_LDR   = 4'h6,
        OP_STR   = 4'h7,
        OP_CONST = 4'h9,
        OP_OTHER = 4'hf    // anything outside the supported subset
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_NONE,          // zero control decodes to this
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B         // CONST takes sext(imm9) as operand b
    } alu_op_e;

    typedef struct packed {
        rsel_t   rs_sel;
        rsel_t   rt_sel;
        rsel_t   rd_sel;
        logic    rs_re;
        logic    rt_re;
        logic    rf_we;
        logic    nzp_we;
        logic    is_load;
        logic    is_store;
        logic    is_branch;
        alu_op_e alu_op;
        logic    imm_sel;  // operand b from the immediate field
    } ctrl_t;

endpackage

// File: verilog/lc4_pipe_pkg.sv
package lc4_pipe_pkg;

    import lc4_isa_pkg::*;

    // code 1 belonged to the second pipe and is never produced
    typedef enum logic [1:0] {
        STALL_NONE  = 2'd0,
        STALL_FLUSH = 2'd2,    // squashed by a taken branch or by reset
        STALL_LOAD  = 2'd3     // bubble behind a load hazard
    } stall_e;

    // one instruction in flight
    typedef struct packed {
        word_t  pc;
        word_t  insn;
        ctrl_t  ctrl;
        stall_e stall;
    } stage_t;

    // what the W stage reports each cycle
    typedef struct packed {
        word_t      pc;
        word_t      insn;
        stall_e     stall;
        logic       rf_we;
        rsel_t      rf_wsel;
        word_t      rf_data;
        logic       nzp_we;
        logic [2:0] nzp_bits;
        logic       dmem_we;
        word_t      dmem_addr;   // zero unless load or store
        word_t      dmem_data;   // load result or store data
    } retire_t;

endpackage

// File: verilog/lc4_decoder.sv
module lc4_decoder (
    input  lc4_isa_pkg::word_t i_insn,
    output lc4_isa_pkg::ctrl_t o_ctrl
);
    import lc4_isa_pkg::*;

    opcode_e op;

    always_comb begin
        case (i_insn[15:12])
            OP_BR, OP_ARITH, OP_LOGIC, OP_LDR, OP_STR, OP_CONST: op = opcode_e'(i_insn[15:12]);
            default: op = OP_OTHER;
        endcase
    end

    always_comb begin
        o_ctrl        = '0;
        o_ctrl.rs_sel = i_insn[8:6];
        o_ctrl.rt_sel = i_insn[2:0];
        o_ctrl.rd_sel = i_insn[11:9];
        case (op)
            OP_ARITH: begin
                if (i_insn[5]) begin                  // add immediate
                    o_ctrl.alu_op  = ALU_ADD;
                    o_ctrl.imm_sel = 1'b1;
                end else if (i_insn[4:3] == 2'b00) begin
                    o_ctrl.alu_op = ALU_ADD;
                end else if (i_insn[4:3] == 2'b10) begin
                    o_ctrl.alu_op = ALU_SUB;
                end
            end
            OP_LOGIC: begin
                if (i_insn[5]) begin                  // and immediate
                    o_ctrl.alu_op  = ALU_AND;
                    o_ctrl.imm_sel = 1'b1;
                end else if (i_insn[4:3] == 2'b00) begin
                    o_ctrl.alu_op = ALU_AND;
                end else if (i_insn[4:3] == 2'b10) begin
                    o_ctrl.alu_op = ALU_OR;
                end else if (i_insn[4:3] == 2'b11) begin
                    o_ctrl.alu_op = ALU_XOR;
                end
            end
            OP_CONST: begin
                o_ctrl.alu_op  = ALU_PASS_B;
                o_ctrl.imm_sel = 1'b1;
            end
            OP_LDR: begin
                o_ctrl.alu_op  = ALU_ADD;             // base + imm6
                o_ctrl.imm_sel = 1'b1;
                o_ctrl.rs_re   = 1'b1;
                o_ctrl.rf_we   = 1'b1;
                o_ctrl.nzp_we  = 1'b1;
                o_ctrl.is_load = 1'b1;
            end
            OP_STR: begin
                o_ctrl.alu_op   = ALU_ADD;
                o_ctrl.imm_sel  = 1'b1;
                o_ctrl.rt_sel   = i_insn[11:9];       // data register
                o_ctrl.rs_re    = 1'b1;
                o_ctrl.rt_re    = 1'b1;
                o_ctrl.is_store = 1'b1;
            end
            OP_BR: o_ctrl.is_branch = 1'b1;
            default: ;
        endcase

        // supported register-writing alu forms
        if ((op == OP_ARITH || op == OP_LOGIC || op == OP_CONST) && o_ctrl.alu_op != ALU_NONE) begin
            o_ctrl.rf_we  = 1'b1;
            o_ctrl.nzp_we = 1'b1;
            o_ctrl.rs_re  = (op != OP_CONST);
            o_ctrl.rt_re  = (op != OP_CONST) && !o_ctrl.imm_sel;
        end
    end

endmodule

// File: verilog/lc4_regfile.sv
`include "lc4_defines.svh"

module lc4_regfile (
    input  logic               gwe,
    input  logic               i_arst_n,
    input  lc4_isa_pkg::rsel_t i_rs_sel,
    input  lc4_isa_pkg::rsel_t i_rt_sel,
    output lc4_isa_pkg::word_t o_rs_data,
    output lc4_isa_pkg::word_t o_rt_data,
    input  lc4_isa_pkg::rsel_t i_rd_sel,
    input  lc4_isa_pkg::word_t i_wdata,
    input  logic               i_we
);
    import lc4_isa_pkg::*;

    word_t regs [`LC4_NUM_REGS];

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < `LC4_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_rd_sel] <= i_wdata;
        end
    end

    // a write in W is visible to the read in D of the same cycle
    assign o_rs_data = (i_we && i_rd_sel == i_rs_sel) ? i_wdata : regs[i_rs_sel];
    assign o_rt_data = (i_we && i_rd_sel == i_rt_sel) ? i_wdata : regs[i_rt_sel];

endmodule

// File: verilog/lc4_execute.sv
module lc4_execute (
    input  lc4_pipe_pkg::stage_t i_x,
    input  lc4_isa_pkg::word_t   i_rs_data,
    input  lc4_isa_pkg::word_t   i_rt_data,
    input  lc4_isa_pkg::rsel_t   i_m_rd,
    input  logic                 i_m_we,
    input  lc4_isa_pkg::word_t   i_m_value,
    input  lc4_isa_pkg::rsel_t   i_w_rd,
    input  logic                 i_w_we,
    input  lc4_isa_pkg::word_t   i_w_value,
    input  logic [2:0]           i_nzp,
    output lc4_isa_pkg::word_t   o_result,
    output lc4_isa_pkg::word_t   o_rt_fwd,
    output logic                 o_br_taken,
    output lc4_isa_pkg::word_t   o_target
);
    import lc4_isa_pkg::*;

    word_t rs_val;
    word_t rt_val;
    word_t imm;
    word_t op_b;

    // MX bypass wins over WX, then the register file
    assign rs_val = (i_m_we && i_m_rd == i_x.ctrl.rs_sel) ? i_m_value :
                    (i_w_we && i_w_rd == i_x.ctrl.rs_sel) ? i_w_value :
                    i_rs_data;
    assign rt_val = (i_m_we && i_m_rd == i_x.ctrl.rt_sel) ? i_m_value :
                    (i_w_we && i_w_rd == i_x.ctrl.rt_sel) ? i_w_value :
                    i_rt_data;

    always_comb begin
        if (i_x.ctrl.is_load || i_x.ctrl.is_store) begin
            imm = {{10{i_x.insn[5]}}, i_x.insn[5:0]};      // imm6 offset
        end else if (i_x.ctrl.alu_op == ALU_PASS_B) begin
            imm = {{7{i_x.insn[8]}}, i_x.insn[8:0]};       // CONST imm9
        end else begin
            imm = {{11{i_x.insn[4]}}, i_x.insn[4:0]};      // imm5 forms
        end
    end

    assign op_b = i_x.ctrl.imm_sel ? imm : rt_val;

    always_comb begin
        case (i_x.ctrl.alu_op)
            ALU_ADD:    o_result = rs_val + op_b;
            ALU_SUB:    o_result = rs_val - op_b;
            ALU_AND:    o_result = rs_val & op_b;
            ALU_OR:     o_result = rs_val | op_b;
            ALU_XOR:    o_result = rs_val ^ op_b;
            ALU_PASS_B: o_result = op_b;
            default:    o_result = '0;
        endcase
    end

    assign o_rt_fwd = rt_val;    // store data heading to M

    // nzp mask sits in insn[11:9]
    assign o_br_taken = i_x.ctrl.is_branch && ((i_x.insn[11:9] & i_nzp) != 3'b000);
    assign o_target   = i_x.pc + 16'd1 + {{7{i_x.insn[8]}}, i_x.insn[8:0]};

endmodule

// File: verilog/lc4_hazard_unit.sv
module lc4_hazard_unit (
    input  lc4_pipe_pkg::stage_t i_d,
    input  lc4_pipe_pkg::stage_t i_x,
    output logic                 o_stall
);

    logic rs_hit;
    logic rt_hit;
    logic load_use;
    logic load_branch;

    assign rs_hit = i_d.ctrl.rs_re && (i_d.ctrl.rs_sel == i_x.ctrl.rd_sel);

    // a store's data register is covered later by the WM bypass
    assign rt_hit = i_d.ctrl.rt_re && (i_d.ctrl.rt_sel == i_x.ctrl.rd_sel)
                    && !i_d.ctrl.is_store;

    assign load_use = i_x.ctrl.is_load && (rs_hit || rt_hit);

    // load nzp only lands in the nzp register at the end of its M cycle
    assign load_branch = i_x.ctrl.is_load && i_d.ctrl.is_branch;

    assign o_stall = load_use || load_branch;

endmodule

// File: verilog/lc4_pipeline.sv
`include "lc4_defines.svh"

module lc4_pipeline (
    input  logic                  gwe,
    input  logic                  i_arst_n,
    output lc4_isa_pkg::word_t    o_cur_pc,
    input  lc4_isa_pkg::word_t    i_cur_insn,
    output lc4_isa_pkg::word_t    o_dmem_addr,
    output logic                  o_dmem_we,
    output lc4_isa_pkg::word_t    o_dmem_towrite,
    input  lc4_isa_pkg::word_t    i_cur_dmem_data,
    output lc4_pipe_pkg::retire_t o_retire
);
    import lc4_isa_pkg::*;
    import lc4_pipe_pkg::*;

    function automatic stage_t bubble(stall_e code);
        stage_t s;
        s       = '0;
        s.stall = code;
        return s;
    endfunction

    word_t      pc_q, pc_next;
    stage_t     d_q, d_next, d_stage;
    stage_t     x_q, x_next;
    stage_t     m_q, w_q;
    logic [2:0] nzp_q;
    ctrl_t      dec_ctrl;
    logic       stall, br_taken;
    word_t      br_target;
    word_t      rs_data, rt_data, x_rs_q, x_rt_q;
    word_t      x_result, x_rt_fwd;
    word_t      m_alu_q, m_rt_q, m_result;
    logic [2:0] m_nzp, br_nzp;
    word_t      w_value_q, w_dmem_addr_q, w_dmem_data_q;
    logic [2:0] w_nzp_q;

    // D stage bubbles decode to zero control
    lc4_decoder u_decoder (.i_insn(d_q.insn), .o_ctrl(dec_ctrl));

    always_comb begin
        d_stage      = d_q;
        d_stage.ctrl = (d_q.stall == STALL_NONE) ? dec_ctrl : '0;
    end

    lc4_regfile u_regfile (
        .gwe(gwe), .i_arst_n(i_arst_n),
        .i_rs_sel(d_stage.ctrl.rs_sel), .i_rt_sel(d_stage.ctrl.rt_sel),
        .o_rs_data(rs_data), .o_rt_data(rt_data),
        .i_rd_sel(w_q.ctrl.rd_sel), .i_wdata(w_value_q), .i_we(w_q.ctrl.rf_we)
    );

    lc4_hazard_unit u_hazard (.i_d(d_stage), .i_x(x_q), .o_stall(stall));

    // loads never forward from M since the stall or the WM path covers them
    lc4_execute u_execute (
        .i_x(x_q), .i_rs_data(x_rs_q), .i_rt_data(x_rt_q),
        .i_m_rd(m_q.ctrl.rd_sel), .i_m_we(m_q.ctrl.rf_we && !m_q.ctrl.is_load),
        .i_m_value(m_alu_q),
        .i_w_rd(w_q.ctrl.rd_sel), .i_w_we(w_q.ctrl.rf_we), .i_w_value(w_value_q),
        .i_nzp(br_nzp),
        .o_result(x_result), .o_rt_fwd(x_rt_fwd),
        .o_br_taken(br_taken), .o_target(br_target)
    );

    // M stage
    assign m_result = m_q.ctrl.is_load ? i_cur_dmem_data : m_alu_q;
    assign m_nzp    = m_result[15] ? 3'b100 : (m_result == '0) ? 3'b010 : 3'b001;
    assign br_nzp   = m_q.ctrl.nzp_we ? m_nzp : nzp_q;    // branch sees the newest flags

    assign o_dmem_addr    = (m_q.ctrl.is_load || m_q.ctrl.is_store) ? m_alu_q : '0;
    assign o_dmem_we      = m_q.ctrl.is_store;
    assign o_dmem_towrite = (m_q.ctrl.is_store && w_q.ctrl.rf_we
                             && w_q.ctrl.rd_sel == m_q.ctrl.rt_sel) ? w_value_q : m_rt_q;

    // fetch and stage steering
    assign o_cur_pc = pc_q;
    assign pc_next  = br_taken ? br_target : stall ? pc_q : pc_q + 16'd1;

    always_comb begin
        if (br_taken) begin
            d_next = bubble(STALL_FLUSH);
            x_next = bubble(STALL_FLUSH);
        end else if (stall) begin
            d_next = d_q;                        // hold F and D
            x_next = bubble(STALL_LOAD);
        end else begin
            d_next       = '0;
            d_next.pc    = pc_q;
            d_next.insn  = i_cur_insn;
            d_next.stall = STALL_NONE;
            x_next       = d_stage;
        end
    end

    always_ff @(posedge gwe or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q  <= `LC4_RESET_PC;
            d_q   <= bubble(STALL_FLUSH);
            x_q   <= bubble(STALL_FLUSH);
            m_q   <= bubble(STALL_FLUSH);
            w_q   <= bubble(STALL_FLUSH);
            nzp_q <= 3'b000;
        end else begin
            pc_q <= pc_next;
            d_q  <= d_next;
            x_q  <= x_next;
            m_q  <= x_q;
            w_q  <= m_q;
            if (m_q.ctrl.nzp_we) begin
                nzp_q <= m_nzp;
            end
        end
    end

    always_ff @(posedge gwe) begin
        x_rs_q        <= rs_data;
        x_rt_q        <= rt_data;
        m_alu_q       <= x_result;
        m_rt_q        <= x_rt_fwd;
        w_value_q     <= m_result;
        w_nzp_q       <= m_nzp;
        w_dmem_addr_q <= o_dmem_addr;
        w_dmem_data_q <= m_q.ctrl.is_load ? i_cur_dmem_data : o_dmem_towrite;
    end

    // W stage record
    assign o_retire = '{
        pc:        w_q.pc,
        insn:      w_q.insn,
        stall:     w_q.stall,
        rf_we:     w_q.ctrl.rf_we,
        rf_wsel:   w_q.ctrl.rd_sel,
        rf_data:   w_value_q,
        nzp_we:    w_q.ctrl.nzp_we,
        nzp_bits:  w_nzp_q,
        dmem_we:   w_q.ctrl.is_store,
        dmem_addr: w_dmem_addr_q,
        dmem_data: w_dmem_data_q
    };

endmodule

// File: tb/lc4_checker.sv
module lc4_checker (
    input logic                  gwe,
    input logic                  i_arst_n,
    input lc4_pipe_pkg::retire_t i_retire,
    input logic                  i_dmem_we
);
    import lc4_pipe_pkg::*;

    int unsigned fail_count = 0;

    // a bubble changes no state
    bubble_quiet: assert property (@(posedge gwe) disable iff (!i_arst_n)
        (i_retire.stall != STALL_NONE) |->
            !(i_retire.rf_we || i_retire.nzp_we || i_retire.dmem_we))
        else begin
            fail_count++;
            $error("retire bubble carries a write enable");
        end

    no_pipe_switch: assert property (@(posedge gwe) disable iff (!i_arst_n)
        i_retire.stall != 2'd1)
        else begin
            fail_count++;
            $error("stall code 1 on a single pipe");
        end

    reset_no_store: assert property (@(posedge gwe) !i_arst_n |-> !i_dmem_we)
        else begin
            fail_count++;
            $error("data memory write during reset");
        end

endmodule

bind lc4_pipeline lc4_checker u_checker (
    .gwe(gwe), .i_arst_n(i_arst_n), .i_retire(o_retire), .i_dmem_we(o_dmem_we)
);

// File: tb/lc4_monitor.sv
module lc4_monitor (
    input  logic                  gwe,
    input  logic                  i_arst_n,
    input  lc4_pipe_pkg::retire_t i_retire,
    output int                    o_errors,
    output int                    o_retired,
    output logic                  o_done
);
    import lc4_pipe_pkg::*;

    logic [15:0] regs [8];
    logic [15:0] mem [65536];
    logic [2:0]  nzp;
    logic [15:0] exp_pc;

    assign o_done = (o_retired >= 400);

    function automatic logic [2:0] sign_flags(logic [15:0] v);
        if (v[15]) begin
            return 3'b100;
        end
        return (v == 16'h0000) ? 3'b010 : 3'b001;
    endfunction

    task automatic compare_field(string field, logic [15:0] expected, logic [15:0] actual);
        if (actual !== expected) begin
            $display("Fail %s at pc %h: expected %h, actual %h", field, exp_pc, expected, actual);
            o_errors++;
        end
    endtask

    // run the instruction at the expected pc and check the record against it
    task automatic step_model();
        logic [15:0] insn, a, b, res, addr, next_pc;
        logic [15:0] imm5, imm6, imm9;
        logic [2:0]  rd;
        logic        wr, ld, st;
        insn    = lc4_tb.imem[exp_pc];
        rd      = insn[11:9];
        a       = regs[insn[8:6]];
        b       = regs[insn[2:0]];
        imm5    = {{11{insn[4]}}, insn[4:0]};
        imm6    = {{10{insn[5]}}, insn[5:0]};
        imm9    = {{7{insn[8]}}, insn[8:0]};
        res     = 16'h0000;
        addr    = 16'h0000;
        next_pc = exp_pc + 16'd1;
        ld      = (insn[15:12] == 4'h6);
        st      = (insn[15:12] == 4'h7);
        wr      = 1'b1;
        case (insn[15:12])
            4'h1: res = insn[5] ? a + imm5 : (insn[4] ? a - b : a + b);
            4'h5: begin
                case (insn[5:3])
                    3'b000:  res = a & b;
                    3'b010:  res = a | b;
                    3'b011:  res = a ^ b;
                    default: res = a & imm5;         // and immediate
                endcase
            end
            4'h9: res = imm9;
            4'h6: begin
                addr = a + imm6;
                res  = mem[addr];
            end
            4'h7: begin
                addr = a + imm6;
                wr   = 1'b0;
            end
            4'h0: begin
                wr = 1'b0;
                if ((insn[11:9] & nzp) != 3'b000) begin
                    next_pc = exp_pc + 16'd1 + imm9;
                end
            end
            default: wr = 1'b0;                      // retires as a NOP
        endcase

        compare_field("pc", exp_pc, i_retire.pc);
        compare_field("insn", insn, i_retire.insn);
        compare_field("rf_we", 16'(wr), 16'(i_retire.rf_we));
        compare_field("nzp_we", 16'(wr), 16'(i_retire.nzp_we));
        compare_field("dmem_we", 16'(st), 16'(i_retire.dmem_we));
        compare_field("dmem_addr", addr, i_retire.dmem_addr);
        if (wr) begin
            compare_field("rf_wsel", 16'(rd), 16'(i_retire.rf_wsel));
            compare_field("rf_data", res, i_retire.rf_data);
            compare_field("nzp_bits", 16'(sign_flags(res)), 16'(i_retire.nzp_bits));
            regs[rd] = res;
            nzp      = sign_flags(res);
        end
        if (ld) begin
            compare_field("dmem_data", res, i_retire.dmem_data);
        end
        if (st) begin
            compare_field("dmem_data", regs[rd], i_retire.dmem_data);
            mem[addr] = regs[rd];
        end
        exp_pc = next_pc;
        o_retired++;
    endtask

    always @(posedge gwe) begin
        if (!i_arst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i[2:0]] = 16'h0000;
            end
            for (int k = 0; k < 65536; k++) begin
                mem[k[15:0]] = k[15:0] ^ 16'h5a5a;   // same fill as the data memory
            end
            nzp       = 3'b000;
            exp_pc    = 16'h8200;
            o_errors  = 0;
            o_retired = 0;
        end else if (i_retire.stall == STALL_NONE && !o_done) begin
            step_model();                            // bubbles are skipped
        end
    end

endmodule

// File: tb/lc4_tb.sv
`include "lc4_defines.svh"

module lc4_tb;
    import lc4_isa_pkg::*;
    import lc4_pipe_pkg::*;

    logic    gwe;
    logic    arst_n;
    word_t   cur_pc, cur_insn;
    word_t   dmem_addr, dmem_towrite, dmem_rdata;
    logic    dmem_we;
    retire_t retire;
    word_t   imem [65536];
    word_t   dmem [65536];
    int      mon_errors, mon_retired, cycles, timeouts;
    logic    mon_done;

    // one random instruction from the supported subset
    function automatic word_t make_insn();
        logic [2:0] rd, rs, rt, base;
        word_t      insn;
        rd   = 3'($urandom % 7);                     // r7 is only written by CONST
        rs   = 3'($urandom);
        rt   = 3'($urandom);
        base = ($urandom % 4 == 0) ? rs : 3'd7;      // mostly r7 so loads and stores meet
        case ($urandom % 12)
            0: insn = {4'h1, rd, rs, 3'b000, rt};            // ADD
            1: insn = {4'h1, rd, rs, 3'b010, rt};            // SUB
            2: insn = {4'h1, rd, rs, 1'b1, 5'($urandom)};    // ADD immediate
            3: insn = {4'h5, rd, rs, 3'b000, rt};            // AND
            4: insn = {4'h5, rd, rs, 3'b010, rt};            // OR
            5: insn = {4'h5, rd, rs, 3'b011, rt};            // XOR
            6: insn = {4'h5, rd, rs, 1'b1, 5'($urandom)};    // AND immediate
            7: insn = {4'h9, 3'($urandom), 9'($urandom)};    // CONST
            8: insn = {4'h6, rd, base, 6'($urandom)};        // LDR
            9: insn = {4'h7, rt, base, 6'($urandom)};        // STR
            default: insn = {4'h0, 3'($urandom), 6'd0, 3'($urandom)};
        endcase
        return insn;                                 // BR offsets 0..7, always forward
    endfunction

    lc4_pipeline dut (
        .gwe(gwe), .i_arst_n(arst_n),
        .o_cur_pc(cur_pc), .i_cur_insn(cur_insn),
        .o_dmem_addr(dmem_addr), .o_dmem_we(dmem_we), .o_dmem_towrite(dmem_towrite),
        .i_cur_dmem_data(dmem_rdata),
        .o_retire(retire)
    );

    lc4_monitor u_monitor (
        .gwe(gwe), .i_arst_n(arst_n), .i_retire(retire),
        .o_errors(mon_errors), .o_retired(mon_retired), .o_done(mon_done)
    );

    // both memories answer in the same cycle
    assign cur_insn   = imem[cur_pc];
    assign dmem_rdata = dmem[dmem_addr];

    always @(posedge gwe) begin
        if (dmem_we) begin
            dmem[dmem_addr] <= dmem_towrite;
        end
    end

    initial begin
        gwe = 1'b0;
        forever #2 gwe = ~gwe;
    end

    initial begin
        void'($urandom(11833));
        arst_n   <= 1'b0;
        timeouts = 0;
        for (int a = 0; a < 65536; a++) begin
            imem[a[15:0]] = 16'h0000;                // BR with empty mask
            dmem[a[15:0]] = a[15:0] ^ 16'h5a5a;
        end
        for (int i = 0; i < 512; i++) begin
            imem[16'(`LC4_RESET_PC + i)] = make_insn();
        end
        repeat (8) @(posedge gwe);
        arst_n <= 1'b1;

        cycles = 0;
        while (!mon_done && cycles < 5000) begin
            @(negedge gwe);
            cycles++;
        end
        if (!mon_done) begin
            $display("Timeout: only %0d of 400 instructions retired in 5000 cycles",
                     mon_retired);
            timeouts = 1;
        end

        $display("model mismatches: %0d, assertion failures: %0d, timeouts: %0d",
                 mon_errors, dut.u_checker.fail_count, timeouts);
        if (mon_errors == 0 && dut.u_checker.fail_count == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+verilog
verilog/lc4_isa_pkg.sv
verilog/lc4_pipe_pkg.sv
verilog/lc4_decoder.sv
verilog/lc4_regfile.sv
verilog/lc4_execute.sv
verilog/lc4_hazard_unit.sv
verilog/lc4_pipeline.sv
tb/lc4_checker.sv
tb/lc4_monitor.sv
tb/lc4_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert --timing
TOP       = lc4_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
RUN_ARGS  = +verilator+error+limit+1000
PASS_MSG  = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
